// File: Bender.yml
package:
  name: dphy_rx_lane

sources:
  - files:
      - hdl/dphy_rx_pkg.sv
      - hdl/dphy_ctrl_if.sv
      - hdl/dphy_lp_sync.sv
      - hdl/dphy_settle_fsm.sv
      - hdl/dphy_settle_timer.sv
      - hdl/dphy_hs_aligner.sv
      - hdl/dphy_rx_lane.sv
  - target: test
    files:
      - dv/dphy_rx_properties.sv
      - dv/tb_dphy_rx_lane.sv

// File: dv/dphy_rx_properties.sv
`timescale 1ns/1ps

module dphy_rx_properties #(
  parameter int T_SETTLE_NS = 300,
  parameter int T_CLK_NS    = 40
)(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  dphy_rx_pkg::lp_state_t  state_i,
  input  logic                    hs_active_i,
  input  logic                    sync_lock_i,
  input  logic                    byte_valid_i
);

import dphy_rx_pkg::*;

localparam int settle_ticks = T_SETTLE_NS / T_CLK_NS;

int fail_cnt = 0; // failures seen so far.

a_valid_locked: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  byte_valid_i |-> sync_lock_i )
  else
    begin
      fail_cnt++;
      $error( "byte_valid_o high without sync_lock_o" );
    end

a_lock_active: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  sync_lock_i |-> hs_active_i )
  else
    begin
      fail_cnt++;
      $error( "sync_lock_o high outside of HS" );
    end

// receiver must not trust the line while it settles.
a_settle_quiet: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  $rose( state_i == LP_00_S ) |-> !hs_active_i [*settle_ticks] )
  else
    begin
      fail_cnt++;
      $error( "hs_active_o rose inside the settle interval" );
    end

endmodule

bind dphy_rx_lane dphy_rx_properties #(
  .T_SETTLE_NS ( T_SETTLE_NS ),
  .T_CLK_NS    ( T_CLK_NS    )
) u_props (
  .clk_i        ( clk_i         ),
  .rst_i        ( rst_i         ),
  .state_i      ( u_fsm.state_q ),
  .hs_active_i  ( hs_active_o   ),
  .sync_lock_i  ( sync_lock_o   ),
  .byte_valid_i ( byte_valid_o  )
);

// File: dv/tb_dphy_rx_lane.sv
`timescale 1ns/1ps

module tb_dphy_rx_lane;

import dphy_rx_pkg::*;

localparam int clk_period_c  = 40;
localparam int timeout_cyc_c = 3000; // six tests of a few hundred cycles each.

logic        clk_i;
logic        rst_i;
logic        lp_p_i;
logic        lp_n_i;
logic        hs_data_i;
logic        hs_active_o;
logic        sync_lock_o;
byte_t       byte_o;
logic        byte_valid_o;

logic [31:0] rng_q;
byte_t       exp_q[$];
byte_t       got_q[$];
int          settle_ticks;
int          cycle_cnt;
int          first_prefix;

dphy_rx_lane #(
  .T_SETTLE_NS ( 300          ),
  .T_CLK_NS    ( clk_period_c )
) DUT (
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .lp_p_i       ( lp_p_i       ),
  .lp_n_i       ( lp_n_i       ),
  .hs_data_i    ( hs_data_i    ),
  .hs_active_o  ( hs_active_o  ),
  .sync_lock_o  ( sync_lock_o  ),
  .byte_o       ( byte_o       ),
  .byte_valid_o ( byte_valid_o )
);

initial
  begin
    clk_i = 1'b0;
    forever
      #( clk_period_c / 2 ) clk_i = ~clk_i;
  end

// every strobe is a full cycle wide, so one sample per cycle sees it once.
always @( negedge clk_i )
  if( byte_valid_o === 1'b1 )
    got_q.push_back( byte_o );

always @( DUT.u_props.fail_cnt )
  if( DUT.u_props.fail_cnt != 0 )
    begin
      $display( "a bound assertion failed at %0t ns", $time );
      $display( "TEST FAIL" );
      $fatal( 1, "assertion failure" );
    end

initial
  begin
    cycle_cnt = 0;
    while( cycle_cnt < timeout_cyc_c )
      begin
        @( posedge clk_i );
        cycle_cnt++;
      end
    $display( "run timed out after %0d cycles before all tests finished", cycle_cnt );
    $display( "TEST FAIL" );
    $fatal( 1, "timeout" );
  end

function automatic logic [31:0] xorshift32( input logic [31:0] x );
  logic [31:0] y;
  y = x ^ ( x << 13 );
  y = y ^ ( y >> 17 );
  y = y ^ ( y << 5 );
  return y;
endfunction

function automatic logic [31:0] next_word();
  rng_q = xorshift32( rng_q );
  return rng_q;
endfunction

task automatic check_byte( input string name, input byte_t exp, input byte_t act );
  if( act !== exp )
    begin
      $display( "[ERROR] %0t ns %s expected 0x%02h got 0x%02h", $time, name, exp, act );
      $display( "TEST FAIL" );
      $fatal( 1, "byte mismatch" );
    end
endtask

task automatic check_level( input string name, input logic exp, input logic act );
  if( act !== exp )
    begin
      $display( "[ERROR] %0t ns %s expected %b got %b", $time, name, exp, act );
      $display( "TEST FAIL" );
      $fatal( 1, "level mismatch" );
    end
endtask

task automatic check_count( input string name, input int exp, input int act );
  if( act != exp )
    begin
      $display( "[ERROR] %0t ns %s expected %0d got %0d", $time, name, exp, act );
      $display( "TEST FAIL" );
      $fatal( 1, "count mismatch" );
    end
endtask

task automatic drive_lp( input logic p, input logic n, input int cycles );
  repeat( cycles )
    begin
      @( posedge clk_i );
      lp_p_i <= p;
      lp_n_i <= n;
    end
endtask

task automatic drive_hs_bit( input logic b );
  @( posedge clk_i );
  hs_data_i <= b;
  @( negedge clk_i );
endtask

task automatic send_byte_lsb( input byte_t b );
  for( int i = 0; i < 8; i++ )
    drive_hs_bit( b[i] );
endtask

// stop, hs request, bridge; returns whole cycles from the LP-00 edge to hs_active_o.
task automatic start_hs( output int settle_cyc );
  drive_lp( 1'b1, 1'b1, 3 );
  drive_lp( 1'b0, 1'b1, 4 );
  drive_lp( 1'b0, 1'b0, 1 );
  settle_cyc = 0;
  @( negedge clk_i );
  while( hs_active_o !== 1'b1 && settle_cyc < 64 )
    begin
      @( negedge clk_i );
      settle_cyc++;
    end
  if( hs_active_o !== 1'b1 )
    begin
      $display( "hs_active_o never rose within 64 cycles of entering LP-00" );
      $display( "TEST FAIL" );
      $fatal( 1, "no hs entry" );
    end
endtask

task automatic send_burst( input int prefix_len, input int n_bytes );
  int    settle_cyc;
  int    k;
  byte_t b;
  start_hs( settle_cyc );
  for( int i = 0; i < prefix_len; i++ )
    drive_hs_bit( 1'b0 );
  send_byte_lsb( sync_byte_c );
  k = 0;
  for( int j = 0; j < n_bytes; j++ )
    begin
      b = byte_t'( next_word() );
      exp_q.push_back( b );
      for( int i = 0; i < 8; i++ )
        begin
          drive_hs_bit( b[i] );
          if( k > 0 ) // lock lands one bit into the payload.
            check_level( "sync_lock_o", 1'b1, sync_lock_o );
          k++;
        end
    end
  repeat( 2 )
    begin
      drive_hs_bit( 1'b0 ); // short tail, ends before another byte boundary.
      check_level( "sync_lock_o", 1'b1, sync_lock_o );
    end
endtask

task automatic end_burst();
  int wait_cyc;
  @( posedge clk_i );
  lp_p_i    <= 1'b1;
  lp_n_i    <= 1'b1;
  hs_data_i <= 1'b0;
  wait_cyc = 0;
  do
    begin
      @( negedge clk_i );
      wait_cyc++;
    end
  while( ( hs_active_o !== 1'b0 || sync_lock_o !== 1'b0 ) && wait_cyc < 4 );
  check_level( "hs_active_o", 1'b0, hs_active_o );
  check_level( "sync_lock_o", 1'b0, sync_lock_o );
endtask

task automatic compare_payload();
  check_count( "byte count", exp_q.size(), got_q.size() );
  foreach( exp_q[i] )
    check_byte( $sformatf( "byte_o[%0d]", i ), exp_q[i], got_q[i] );
  exp_q.delete();
  got_q.delete();
endtask

task automatic test_reset_idle();
  check_level( "hs_active_o", 1'b0, hs_active_o );
  check_level( "sync_lock_o", 1'b0, sync_lock_o );
  check_level( "byte_valid_o", 1'b0, byte_valid_o );
  repeat( 20 )
    begin
      @( negedge clk_i );
      check_level( "hs_active_o", 1'b0, hs_active_o );
      check_level( "sync_lock_o", 1'b0, sync_lock_o );
      check_level( "byte_valid_o", 1'b0, byte_valid_o );
    end
endtask

task automatic test_settle_timing();
  int settle_cyc;
  start_hs( settle_cyc );
  // two sync flops, one fsm step, the settle count, one more fsm step.
  check_count( "hs_active_o delay", 2 + 1 + settle_ticks + 1, settle_cyc );
  end_burst();
  check_count( "byte count", 0, got_q.size() );
endtask

task automatic test_aligned_burst();
  first_prefix = next_word() % 8;
  send_burst( first_prefix, 16 );
  end_burst();
  compare_payload();
endtask

task automatic test_bit_offset();
  int prefix;
  prefix = ( first_prefix + 1 + next_word() % 7 ) % 8;
  send_burst( prefix, 12 );
  end_burst();
  compare_payload();
endtask

task automatic test_end_of_burst();
  int n_got;
  send_burst( next_word() % 8, 4 );
  end_burst();
  n_got = got_q.size();
  repeat( 12 )
    begin
      @( negedge clk_i );
      check_level( "byte_valid_o", 1'b0, byte_valid_o );
    end
  check_count( "byte count after stop", n_got, got_q.size() );
  compare_payload();
endtask

task automatic test_bad_sequence();
  drive_lp( 1'b1, 1'b1, 4 );
  drive_lp( 1'b0, 1'b0, 1 ); // no LP-01 step.
  repeat( 2 + 1 + settle_ticks + 1 + 8 )
    begin
      @( negedge clk_i );
      check_level( "hs_active_o", 1'b0, hs_active_o );
    end
  send_byte_lsb( sync_byte_c );
  repeat( 4 )
    send_byte_lsb( byte_t'( next_word() ) );
  check_level( "hs_active_o", 1'b0, hs_active_o );
  check_count( "byte count", 0, got_q.size() );
  drive_lp( 1'b1, 1'b1, 4 );
endtask

initial
  begin
    rst_i     = 1'b1;
    lp_p_i    = 1'b1;
    lp_n_i    = 1'b1;
    hs_data_i = 1'b0;
    rng_q     = 32'hc415_fd1d;
    settle_ticks = DUT.T_SETTLE_NS / DUT.T_CLK_NS;
    repeat( 2 )
      @( posedge clk_i );
    rst_i <= 1'b0;
    @( negedge clk_i );
    test_reset_idle();
    test_settle_timing();
    test_aligned_burst();
    test_bit_offset();
    test_end_of_burst();
    test_bad_sequence();
    if( DUT.u_props.fail_cnt != 0 )
      begin
        $display( "bound assertions failed %0d times", DUT.u_props.fail_cnt );
        $display( "TEST FAIL" );
        $fatal( 1, "assertion failures" );
      end
    else
      begin
        $display( "TEST PASS" );
        $finish;
      end
  end

endmodule

// File: filelist.f
hdl/dphy_rx_pkg.sv
hdl/dphy_ctrl_if.sv
hdl/dphy_lp_sync.sv
hdl/dphy_settle_fsm.sv
hdl/dphy_settle_timer.sv
hdl/dphy_hs_aligner.sv
hdl/dphy_rx_lane.sv
dv/dphy_rx_properties.sv
dv/tb_dphy_rx_lane.sv

// File: hdl/dphy_ctrl_if.sv
`timescale 1ns/1ps

// control levels shared by the lane blocks.
interface dphy_ctrl_if;

logic lp_p;        // synchronized lp line, positive leg.
logic lp_n;        // synchronized lp line, negative leg.
logic settle_run;  // fsm sits in the bridge state.
logic settle_done; // settle interval has elapsed.
logic hs_active;   // HS bits on the line are meaningful.

modport sync_mp (
  output lp_p,
  output lp_n
);

modport fsm_mp (
  input  lp_p,
  input  lp_n,
  input  settle_done,
  output settle_run,
  output hs_active
);

modport timer_mp (
  input  settle_run,
  output settle_done
);

modport aligner_mp (
  input  hs_active
);

endinterface

// File: hdl/dphy_hs_aligner.sv
`timescale 1ns/1ps

module dphy_hs_aligner (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               hs_data_i,
  dphy_ctrl_if.aligner_mp    ctrl,
  output logic               sync_lock_o,
  output dphy_rx_pkg::byte_t byte_o,
  output logic               byte_valid_o
);

import dphy_rx_pkg::*;

// the transmitter sends HS-zero ahead of the sync byte.
localparam byte_t hs_zero_c = 8'h00;

// newest bit enters at the top, so [15:8] is the last byte on the line.
// [7:0] holds the byte before it.
logic [15 : 0] shift_q;
logic          lock_q;
bit_ofs_t      bit_cnt_q;
bit_ofs_t      phase_q;
logic          valid_q;
logic          sync_hit;
logic          byte_end;

// sync must follow a quiet line, not a random pattern in noise.
assign sync_hit = !lock_q && ( shift_q == { sync_byte_c, hs_zero_c } );

// a byte is complete every eighth bit after the sync byte.
assign byte_end = lock_q && ( bit_cnt_q == phase_q );

// serial to parallel, flushed between bursts.
always_ff @( posedge clk_i )
  if( !ctrl.hs_active )
    shift_q <= '0;
  else
    shift_q <= { hs_data_i, shift_q[15 : 1] };

// free running bit position inside the burst.
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    bit_cnt_q <= '0;
  else
    if( !ctrl.hs_active )
      bit_cnt_q <= '0;
    else
      bit_cnt_q <= bit_cnt_q + 1'b1; // wraps modulo 8.

// lock remembers where in the 8 bit cycle the sync byte ended.
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      lock_q  <= 1'b0;
      phase_q <= '0;
    end
  else
    if( !ctrl.hs_active )
      begin
        lock_q  <= 1'b0;
        phase_q <= '0;
      end
    else
      if( sync_hit )
        begin
          lock_q  <= 1'b1;
          phase_q <= bit_cnt_q;
        end

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    valid_q <= 1'b0;
  else
    valid_q <= ctrl.hs_active && byte_end; // single cycle strobe.

// sync byte is never copied here, first hit is 8 bits past it.
always_ff @( posedge clk_i )
  if( byte_end )
    byte_o <= shift_q[15 : 8];

// drop lock and strobe as soon as the line leaves HS.
assign sync_lock_o  = lock_q  && ctrl.hs_active;
assign byte_valid_o = valid_q && ctrl.hs_active;

endmodule

// File: hdl/dphy_lp_sync.sv
`timescale 1ns/1ps

module dphy_lp_sync (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        lp_p_i,
  input  logic        lp_n_i,
  dphy_ctrl_if.sync_mp ctrl
);

// the lp receivers are slow and unrelated to clk_i.
logic lp_p_d1;
logic lp_p_d2;
logic lp_n_d1;
logic lp_n_d2;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      lp_p_d1 <= 1'b0;
      lp_p_d2 <= 1'b0;
      lp_n_d1 <= 1'b0;
      lp_n_d2 <= 1'b0;
    end
  else
    begin
      lp_p_d1 <= lp_p_i;  // first stage may go metastable.
      lp_p_d2 <= lp_p_d1;
      lp_n_d1 <= lp_n_i;
      lp_n_d2 <= lp_n_d1;
    end

assign ctrl.lp_p = lp_p_d2;
assign ctrl.lp_n = lp_n_d2;

endmodule

// File: hdl/dphy_rx_lane.sv
`timescale 1ns/1ps

module dphy_rx_lane #(
  parameter int T_SETTLE_NS = 300,
  parameter int T_CLK_NS    = 40
)(
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               lp_p_i,
  input  logic               lp_n_i,
  input  logic               hs_data_i,
  output logic               hs_active_o,
  output logic               sync_lock_o,
  output dphy_rx_pkg::byte_t byte_o,
  output logic               byte_valid_o
);

dphy_ctrl_if ctrl ();

dphy_lp_sync u_lp_sync (
  .clk_i  ( clk_i  ),
  .rst_i  ( rst_i  ),
  .lp_p_i ( lp_p_i ),
  .lp_n_i ( lp_n_i ),
  .ctrl   ( ctrl   )
);

dphy_settle_fsm u_fsm (
  .clk_i ( clk_i ),
  .rst_i ( rst_i ),
  .ctrl  ( ctrl  )
);

dphy_settle_timer #(
  .T_SETTLE_NS ( T_SETTLE_NS ),
  .T_CLK_NS    ( T_CLK_NS    )
) u_timer (
  .clk_i ( clk_i ),
  .rst_i ( rst_i ),
  .ctrl  ( ctrl  )
);

dphy_hs_aligner u_aligner (
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .hs_data_i    ( hs_data_i    ),
  .ctrl         ( ctrl         ),
  .sync_lock_o  ( sync_lock_o  ),
  .byte_o       ( byte_o       ),
  .byte_valid_o ( byte_valid_o )
);

assign hs_active_o = ctrl.hs_active;

endmodule

// File: hdl/dphy_rx_pkg.sv
package dphy_rx_pkg;

// one payload byte as delivered by the lane.
typedef logic [7:0] byte_t;

// bit position inside the 8-bit deserializer window.
typedef logic [2:0] bit_ofs_t;

// D-PHY line states seen on the LP pair, plus the HS burst itself.
typedef enum logic [2:0] {
  LP_IDLE_S, // out of reset, line not yet seen at stop state.
  LP_11_S,   // stop state.
  LP_01_S,   // hs request.
  LP_00_S,   // bridge, HS receiver settling.
  HS_S       // high speed data on the line.
} lp_state_t;

// leader sequence sent by the transmitter ahead of the payload.
// bits go out LSB first, so the line shows 0,0,0,1,1,1,0,1.
localparam byte_t sync_byte_c = 8'hB8;

endpackage

// File: hdl/dphy_settle_fsm.sv
`timescale 1ns/1ps

module dphy_settle_fsm (
  input  logic        clk_i,
  input  logic        rst_i,
  dphy_ctrl_if.fsm_mp ctrl
);

import dphy_rx_pkg::*;

lp_state_t state_q;
lp_state_t state_d;
logic      lp_11;
logic      lp_01;
logic      lp_00;

// decoded line states, p leg first.
assign lp_11 =  ctrl.lp_p &&  ctrl.lp_n;
assign lp_01 = !ctrl.lp_p &&  ctrl.lp_n;
assign lp_00 = !ctrl.lp_p && !ctrl.lp_n;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    state_q <= LP_IDLE_S;
  else
    state_q <= state_d;

// start of transmission is 11 -> 01 -> 00, anything else stalls in place.
always_comb
  begin
    state_d = state_q;
    case( state_q )
      LP_IDLE_S:
        begin
          if( lp_11 )
            state_d = LP_11_S;
        end
      LP_11_S:
        begin
          if( lp_01 )
            state_d = LP_01_S;
        end
      LP_01_S:
        begin
          if( lp_00 )
            state_d = LP_00_S;
        end
      LP_00_S:
        begin
          if( ctrl.settle_done ) // receiver settled, trust the hs line.
            state_d = HS_S;
        end
      HS_S:
        begin
          if( lp_11 )            // stop state ends the burst.
            state_d = LP_11_S;
        end
      default:
        begin
          state_d = LP_IDLE_S;
        end
    endcase
  end

assign ctrl.settle_run = ( state_q == LP_00_S );
assign ctrl.hs_active  = ( state_q == HS_S );

endmodule

// File: hdl/dphy_settle_timer.sv
`timescale 1ns/1ps

module dphy_settle_timer #(
  parameter int T_SETTLE_NS = 300,
  parameter int T_CLK_NS    = 40
)(
  input  logic          clk_i,
  input  logic          rst_i,
  dphy_ctrl_if.timer_mp ctrl
);

localparam int settle_ticks = T_SETTLE_NS / T_CLK_NS;
// one extra count value so a power of two tick count is reachable.
localparam int cnt_w        = ( settle_ticks > 0 ) ? $clog2( settle_ticks + 1 ) : 1;

logic [cnt_w - 1 : 0] tick_cnt;
logic                 at_limit;

assign at_limit = ( tick_cnt == cnt_w'( settle_ticks ) );

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    tick_cnt <= '0;
  else
    if( !ctrl.settle_run )
      tick_cnt <= '0;              // restart on every new bridge state.
    else
      if( !at_limit )
        tick_cnt <= tick_cnt + 1'b1; // hold at the limit.

assign ctrl.settle_done = at_limit;

endmodule
